/* gb_memory_system.f */
+incdir+verilog
verilog/gb_bus_pkg.sv
verilog/bus_arbiter.sv
verilog/oam_dma.sv
verilog/memory_map.sv
verilog/internal_ram.sv
verilog/interrupt_flags.sv
verilog/gb_memory_system.sv
test/tb_gb_memory_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory system testbench with Verilator and run it.
# Exits nonzero unless the testbench reports a pass.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f gb_memory_system.f \
   --top-module tb_gb_memory_system -o tb_sim || exit 1
result=$(./obj_dir/tb_sim)
echo "$result"
echo "$result" | grep -qx '>>> PASS' && echo "Simulation passed" || {
   echo "Simulation failed"
   exit 1
}

/* test/tb_gb_memory_system.sv */
//####################################################################
// Testbench for the CPU-side memory system. Drives the CPU port on
// the falling edge, models the flash, keeps a shadow of the memories
// and checks every read response against a reference function.
//####################################################################

`timescale 1ns/10ps
`default_nettype none
`include "gb_bus_defs.svh"

module tb_gb_memory_system import gb_bus_pkg::*; ();

   localparam int MAX_CYCLES = 4000;

   logic        clock;
   logic        reset;
   bus_req_t    cpu_req;
   logic [7:0]  rom_data;
   irq_bits_t   irq_req;
   logic        cpu_stall;
   logic        cpu_rd_valid;
   logic [7:0]  cpu_rd_data;
   logic [23:0] rom_addr;
   logic        irq;
   logic        dma_busy;

   // Shadow state for the reference function
   logic [7:0]  wram_shadow [0:8191];
   logic [7:0]  oam_shadow [0:`GB_OAM_BYTES-1];
   irq_bits_t   if_shadow;
   irq_bits_t   ie_shadow;
   logic [7:0]  boot_shadow;
   logic [7:0]  page_shadow;

   // Reads accepted and not yet answered
   logic [7:0]  exp_data [$];
   int          exp_due [$];
   string       exp_name [$];
   int          cycle_count = 0;
   int          error_count = 0;

   gb_memory_system dut (
      .clock        (clock),
      .reset        (reset),
      .cpu_req      (cpu_req),
      .rom_data     (rom_data),
      .irq_req      (irq_req),
      .cpu_stall    (cpu_stall),
      .cpu_rd_valid (cpu_rd_valid),
      .cpu_rd_data  (cpu_rd_data),
      .rom_addr     (rom_addr),
      .irq          (irq),
      .dma_busy     (dma_busy)
   );

   // Flash model
   assign rom_data = rom_addr[7:0] ^ rom_addr[15:8];

   initial clock = 1'b0;
   always #5 clock = ~clock;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", cycle_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Boot image below the window end while the overlay is on
   function automatic logic [23:0] flash_addr(input logic [15:0] addr);
      if (!boot_shadow[0] && addr <= `GB_BOOT_WINDOW_END)
         flash_addr = {8'h00, addr};
      else
         flash_addr = {8'h00, addr} + 24'(`GB_CART_OFFSET);
   endfunction

   function automatic logic [7:0] ref_read(input logic [15:0] addr);
      logic [23:0] flash;
      logic [15:0] offset;
      logic [7:0]  value;
      value = 8'h00;
      if (addr <= `GB_CART_END) begin
         flash = flash_addr(addr);
         value = flash[7:0] ^ flash[15:8];
      end else if (addr >= `GB_WRAM_START && addr <= `GB_WRAM_END) begin
         offset = addr - `GB_WRAM_START;
         value  = wram_shadow[offset[12:0]];
      end else if (addr >= `GB_ECHO_START && addr <= `GB_ECHO_END) begin
         offset = addr - `GB_ECHO_START;
         value  = wram_shadow[offset[12:0]];
      end else if (addr >= `GB_OAM_START && addr <= `GB_OAM_END) begin
         offset = addr - `GB_OAM_START;
         value  = oam_shadow[offset[7:0]];
      end else if (addr == `GB_MMIO_IF) begin
         value = {3'b000, if_shadow};
      end else if (addr == `GB_MMIO_IE) begin
         value = {3'b000, ie_shadow};
      end else if (addr == `GB_MMIO_BOOT) begin
         value = boot_shadow;
      end else if (addr == `GB_MMIO_DMA) begin
         value = page_shadow;
      end
      return value;
   endfunction

   // ROM and unmapped writes leave the shadow alone
   function automatic void update_shadow(input logic [15:0] addr, input logic [7:0] data);
      logic [15:0] offset;
      if (addr >= `GB_WRAM_START && addr <= `GB_WRAM_END) begin
         offset = addr - `GB_WRAM_START;
         wram_shadow[offset[12:0]] = data;
      end else if (addr >= `GB_ECHO_START && addr <= `GB_ECHO_END) begin
         offset = addr - `GB_ECHO_START;
         wram_shadow[offset[12:0]] = data;
      end else if (addr >= `GB_OAM_START && addr <= `GB_OAM_END) begin
         offset = addr - `GB_OAM_START;
         oam_shadow[offset[7:0]] = data;
      end else if (addr == `GB_MMIO_IF) begin
         if_shadow        = irq_bits_t'(data[4:0]);
         if_shadow.serial = 1'b0;
      end else if (addr == `GB_MMIO_IE) begin
         ie_shadow = irq_bits_t'(data[4:0]);
      end else if (addr == `GB_MMIO_BOOT) begin
         boot_shadow = data;
      end else if (addr == `GB_MMIO_DMA) begin
         page_shadow = data;
      end
   endfunction

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %02h, actual %02h", name, expected, actual);
      end
   endtask

   task automatic check_irq(input string name, input irq_bits_t expected,
                            input irq_bits_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %05b, actual %05b", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic check_rom_addr(input string name, input logic [23:0] expected,
                                 input logic [23:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %06h, actual %06h", name, expected, actual);
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         error_count++;
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   function automatic void drop_front();
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
      void'(exp_name.pop_front());
   endfunction

   // Flash address of every CPU ROM read at its accepting edge
   always @(posedge clock) begin
      if (!reset && cpu_req.valid && !cpu_req.we && !cpu_stall &&
          cpu_req.addr <= `GB_CART_END)
         check_rom_addr("flash address", flash_addr(cpu_req.addr), rom_addr);
   end

   // Each response must land in the cycle right after its accepting edge
   always @(negedge clock) begin
      if (!reset) begin
         if (exp_due.size() > 0 && exp_due[0] < cycle_count) begin
            error_count++;
            $display("Read for %s got no response in the cycle after acceptance",
                     exp_name[0]);
            drop_front();
         end
         if (cpu_rd_valid) begin
            if (exp_data.size() == 0) begin
               error_count++;
               $display("Read response at cycle %0d with no read outstanding", cycle_count);
            end else begin
               if (exp_due[0] != cycle_count) begin
                  error_count++;
                  $display("Read response for %s arrived early", exp_name[0]);
               end
               check_byte(exp_name[0], exp_data[0], cpu_rd_data);
               drop_front();
            end
         end
      end
   end

   // Called at the falling edge before the accepting edge
   task automatic expect_read(input logic [15:0] addr, input string name);
      exp_data.push_back(ref_read(addr));
      exp_due.push_back(cycle_count + 1);
      exp_name.push_back(name);
   endtask

   // One access, held while stalled, returns at the accepting edge
   task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [7:0] data,
                             input string name);
      @(negedge clock);
      cpu_req.valid = 1'b1;
      cpu_req.we    = we;
      cpu_req.addr  = addr;
      cpu_req.wdata = data;
      while (cpu_stall) begin
         @(negedge clock);
      end
      if (we)
         update_shadow(addr, data);
      else
         expect_read(addr, name);
      @(posedge clock);
   endtask

   task automatic cpu_idle();
      @(negedge clock);
      cpu_req = '0;
   endtask

   task automatic pulse_irq(input irq_bits_t bits);
      @(negedge clock);
      irq_req          = bits;
      if_shadow        = irq_bits_t'(if_shadow | bits);
      if_shadow.serial = 1'b0;
      @(negedge clock);
      irq_req = '0;
   endtask

   task automatic irq_status(input string name);
      check_irq({name, " IF"}, if_shadow, dut.if_q);
      check_irq({name, " IE"}, ie_shadow, dut.ie_q);
      check_bit({name, " irq"}, |(if_shadow & ie_shadow), irq);
   endtask

   task automatic test_wram();
      logic [15:0] addrs [$];
      logic [15:0] echo_addr;
      for (int i = 0; i < 8; i++) begin
         addrs.push_back(`GB_WRAM_START + 16'($urandom_range(0, 16'h1DFF)));
         cpu_access(1'b1, addrs[i], 8'($urandom), "wram write");
      end
      for (int i = 0; i < 8; i++)
         cpu_access(1'b0, addrs[i], 8'h00, "wram read");
      for (int i = 0; i < 8; i++)
         cpu_access(1'b0, addrs[i] + 16'h2000, 8'h00, "echo read");
      // Written through the mirror, read back directly
      echo_addr = `GB_ECHO_START + 16'($urandom_range(0, 16'h1DFF));
      cpu_access(1'b1, echo_addr, 8'($urandom), "echo write");
      cpu_access(1'b0, echo_addr - 16'h2000, 8'h00, "wram read after echo write");
      cpu_idle();
   endtask

   task automatic test_rom();
      logic [15:0] addrs [$];
      addrs = '{16'h0000, 16'h0042, 16'h0103, 16'h0104, 16'h0150, 16'h7FFF};
      addrs.push_back(16'h0105 + 16'($urandom_range(0, 16'h7EFA)));
      foreach (addrs[i])
         cpu_access(1'b0, addrs[i], 8'h00, "rom read with boot overlay");
      cpu_access(1'b1, `GB_MMIO_BOOT, 8'h01, "boot overlay off");
      foreach (addrs[i])
         cpu_access(1'b0, addrs[i], 8'h00, "rom read cartridge");
      cpu_access(1'b0, `GB_MMIO_BOOT, 8'h00, "boot register read");
      cpu_idle();
   endtask

   task automatic test_unmapped();
      logic [15:0] addrs [$];
      addrs = '{16'hA000, 16'hBFFF, 16'hFEA0, 16'hFEFF, 16'hFF00, 16'hFF10,
                16'hFF7F, 16'hFF80, 16'hFFFE};
      foreach (addrs[i])
         cpu_access(1'b0, addrs[i], 8'h00, "unmapped read");
      // Work RAM bytes that share the low address bits of the ROM writes
      cpu_access(1'b1, 16'hC150, 8'h11, "wram alias setup");
      cpu_access(1'b1, 16'hDFFF, 8'h22, "wram alias setup");
      cpu_access(1'b1, 16'h0150, 8'h5A, "rom write");
      cpu_access(1'b1, 16'h7FFF, 8'hA5, "rom write");
      cpu_access(1'b1, 16'hFF80, 8'h3C, "unmapped write");
      cpu_access(1'b0, 16'hC150, 8'h00, "wram alias after rom write");
      cpu_access(1'b0, 16'hDFFF, 8'h00, "wram alias after rom write");
      cpu_access(1'b0, `GB_MMIO_BOOT, 8'h00, "boot register after rom write");
      cpu_access(1'b0, 16'hFF80, 8'h00, "unmapped read after write");
      cpu_idle();
   endtask

   task automatic test_irq();
      irq_bits_t bits;
      bits        = '0;
      bits.vblank = 1'b1;
      pulse_irq(bits);
      irq_status("vblank pending, not enabled");
      cpu_access(1'b0, `GB_MMIO_IF, 8'h00, "IF read");
      cpu_access(1'b1, `GB_MMIO_IE, 8'h02, "IE write");
      cpu_idle();
      irq_status("lcdc enabled, vblank pending");
      bits      = '0;
      bits.lcdc = 1'b1;
      pulse_irq(bits);
      irq_status("lcdc pending and enabled");
      cpu_access(1'b1, `GB_MMIO_IF, 8'h00, "IF clear");
      cpu_idle();
      irq_status("flags cleared");
      bits        = '0;
      bits.serial = 1'b1;
      pulse_irq(bits);
      irq_status("serial request");
      cpu_access(1'b1, `GB_MMIO_IE, 8'hFF, "IE write all");
      cpu_access(1'b1, `GB_MMIO_IF, 8'hFF, "IF write all");
      cpu_access(1'b0, `GB_MMIO_IF, 8'h00, "IF read top bits");
      cpu_access(1'b0, `GB_MMIO_IE, 8'h00, "IE read top bits");
      cpu_idle();
      irq_status("all flags written");
      cpu_access(1'b1, `GB_MMIO_IF, 8'h00, "IF clear");
      cpu_access(1'b1, `GB_MMIO_IE, 8'h00, "IE clear");
      cpu_idle();
      irq_status("registers cleared");
   endtask

   task automatic test_dma();
      int          busy_cycles;
      logic [15:0] held_addr;
      for (int i = 0; i < `GB_OAM_BYTES; i++)
         cpu_access(1'b1, 16'hC100 + 16'(i), 8'($urandom), "page fill");
      cpu_access(1'b1, `GB_MMIO_DMA, 8'hC1, "dma start");
      cpu_idle();
      // Present a read once the copy is running and keep it there
      held_addr = `GB_OAM_START + 16'h0010;
      @(negedge clock);
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b0;
      cpu_req.addr  = held_addr;
      cpu_req.wdata = 8'h00;
      busy_cycles   = 0;
      while (dma_busy) begin
         check_bit("cpu stall during dma", 1'b1, cpu_stall);
         busy_cycles++;
         @(negedge clock);
      end
      check_count("dma busy cycles", 2 * `GB_OAM_BYTES, busy_cycles);
      check_bit("stall released", 1'b0, cpu_stall);
      for (int i = 0; i < `GB_OAM_BYTES; i++)
         oam_shadow[8'(i)] = wram_shadow[13'(16'h0100 + i)];
      expect_read(held_addr, "held read after dma");
      @(posedge clock);
      for (int i = 0; i < `GB_OAM_BYTES; i++)
         cpu_access(1'b0, `GB_OAM_START + 16'(i), 8'h00, "oam after dma");
      cpu_idle();
   endtask

   initial begin
      void'($urandom(76144));
      reset       = 1'b1;
      cpu_req     = '0;
      irq_req     = '0;
      if_shadow   = '0;
      ie_shadow   = '0;
      boot_shadow = 8'h00;
      page_shadow = 8'h00;
      repeat (2) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      check_bit("rd_valid after reset", 1'b0, cpu_rd_valid);
      check_bit("dma_busy after reset", 1'b0, dma_busy);
      check_bit("cpu_stall after reset", 1'b0, cpu_stall);
      irq_status("after reset");

      test_wram();
      test_rom();
      test_unmapped();
      test_irq();
      test_dma();

      while (exp_data.size() > 0) begin
         @(negedge clock);
      end
      repeat (2) @(negedge clock);
      $display("Run complete after %0d cycles, %0d errors", cycle_count, error_count);
      if (error_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
//####################################################################
// Shared bus arbiter. DMA owns the bus while it runs and the CPU is
// stalled; read responses go back to whichever master issued them.
//####################################################################

`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import gb_bus_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  bus_req_t   cpu_req,
   input  bus_req_t   dma_req,
   input  logic       dma_busy,
   input  bus_rsp_t   rsp,
   output bus_req_t   grant_req,
   output bus_owner_e grant_owner,
   output logic       cpu_stall,
   output logic       cpu_rd_valid,
   output logic [7:0] cpu_rd_data,
   output bus_rsp_t   dma_rsp
);

   // Request side
   always_comb begin
      if (dma_busy) begin
         grant_req   = dma_req;
         grant_owner = OWNER_DMA;
      end else begin
         grant_req   = cpu_req;
         grant_owner = OWNER_CPU;
      end
   end

   assign cpu_stall = dma_busy;

   // Response side, steered by the owner tag
   assign cpu_rd_valid = rsp.valid && (rsp.owner == OWNER_CPU);
   assign cpu_rd_data  = rsp.data;

   always_comb begin
      dma_rsp       = rsp;
      dma_rsp.valid = rsp.valid && (rsp.owner == OWNER_DMA);
   end

   // A CPU read returning now was accepted while DMA was idle
   a_no_cpu_grant_in_dma: assert property (
      @(posedge clock) disable iff (reset)
      (rsp.valid && rsp.owner == OWNER_CPU) |-> !$past(dma_busy)
   );

endmodule

`default_nettype wire

/* verilog/gb_bus_defs.svh */
//####################################################################
// Memory map bounds, register addresses and storage sizes of the
// console's CPU-side bus. Include in any module that decodes or
// sizes against the memory map.
//####################################################################

`ifndef GB_BUS_DEFS_SVH
`define GB_BUS_DEFS_SVH

// Memory regions
`define GB_WRAM_START      16'hC000
`define GB_WRAM_END        16'hDFFF
`define GB_ECHO_START      16'hE000
`define GB_ECHO_END        16'hFDFF
`define GB_OAM_START       16'hFE00
`define GB_OAM_END         16'hFE9F
`define GB_CART_END        16'h7FFF

// Boot image window and cartridge placement in flash
`define GB_BOOT_WINDOW_END 16'h0103
`define GB_CART_OFFSET     16'h0104

// Registers
`define GB_MMIO_IF         16'hFF0F
`define GB_MMIO_IE         16'hFFFF
`define GB_MMIO_DMA        16'hFF46
`define GB_MMIO_BOOT       16'hFF50

// Sizes
`define GB_WRAM_ADDR_BITS  13
`define GB_OAM_BYTES       160
`define GB_ROM_ADDR_WIDTH  24

`endif

/* verilog/gb_bus_pkg.sv */
//####################################################################
// Types shared by the masters, the arbiter and the targets of the
// CPU-side bus. Modules import it with a wildcard in their header.
//####################################################################

`default_nettype none

package gb_bus_pkg;

   // One access on the shared bus
   typedef struct packed {
      logic        valid;
      logic        we;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } bus_req_t;

   typedef enum logic {
      OWNER_CPU = 1'b0,
      OWNER_DMA = 1'b1
   } bus_owner_e;

   // Read data, tagged with the master that asked for it
   typedef struct packed {
      logic       valid;
      bus_owner_e owner;
      logic [7:0] data;
   } bus_rsp_t;

   typedef enum logic [2:0] {
      TGT_ROM,
      TGT_WRAM,
      TGT_OAM,
      TGT_IF,
      TGT_IE,
      TGT_BOOT,
      TGT_DMA,
      TGT_NONE
   } bus_target_e;

   // Same bit order as the IF and IE registers
   typedef struct packed {
      logic joypad;
      logic serial;
      logic timer;
      logic lcdc;
      logic vblank;
   } irq_bits_t;

   typedef enum logic [1:0] {
      DMA_IDLE,
      DMA_READ,
      DMA_WRITE
   } dma_state_e;

endpackage

`default_nettype wire

/* verilog/gb_memory_system.sv */
//####################################################################
// Top of the CPU-side memory system. The external CPU port and the
// OAM DMA engine share one bus through the arbiter; the decoder
// fans accesses out to flash, on-chip RAM and interrupt registers.
//####################################################################

`timescale 1ns/10ps
`default_nettype none
`include "gb_bus_defs.svh"

module gb_memory_system import gb_bus_pkg::*; (
   input  logic                          clock,
   input  logic                          reset,
   input  bus_req_t                      cpu_req,
   input  logic [7:0]                    rom_data,
   input  irq_bits_t                     irq_req,
   output logic                          cpu_stall,
   output logic                          cpu_rd_valid,
   output logic [7:0]                    cpu_rd_data,
   output logic [`GB_ROM_ADDR_WIDTH-1:0] rom_addr,
   output logic                          irq,
   output logic                          dma_busy
);

   // Bus
   bus_req_t   dma_req;
   bus_req_t   grant_req;
   bus_owner_e grant_owner;
   bus_rsp_t   rsp;
   bus_rsp_t   dma_rsp;

   // Target side
   logic                          ram_we_wram;
   logic                          ram_we_oam;
   logic [`GB_WRAM_ADDR_BITS-1:0] wram_addr;
   logic [7:0]                    oam_addr;
   logic [7:0]                    wdata;
   logic [7:0]                    wram_rdata;
   logic [7:0]                    oam_rdata;
   logic                          if_we;
   logic                          ie_we;
   irq_bits_t                     if_q;
   irq_bits_t                     ie_q;
   logic                          dma_start;
   logic [7:0]                    dma_page;

   bus_arbiter u_arbiter (
      .clock        (clock),
      .reset        (reset),
      .cpu_req      (cpu_req),
      .dma_req      (dma_req),
      .dma_busy     (dma_busy),
      .rsp          (rsp),
      .grant_req    (grant_req),
      .grant_owner  (grant_owner),
      .cpu_stall    (cpu_stall),
      .cpu_rd_valid (cpu_rd_valid),
      .cpu_rd_data  (cpu_rd_data),
      .dma_rsp      (dma_rsp)
   );

   oam_dma u_dma (
      .clock     (clock),
      .reset     (reset),
      .dma_start (dma_start),
      .dma_page  (dma_page),
      .dma_rsp   (dma_rsp),
      .dma_req   (dma_req),
      .dma_busy  (dma_busy)
   );

   memory_map u_map (
      .clock       (clock),
      .reset       (reset),
      .grant_req   (grant_req),
      .grant_owner (grant_owner),
      .rom_data    (rom_data),
      .wram_rdata  (wram_rdata),
      .oam_rdata   (oam_rdata),
      .if_q        (if_q),
      .ie_q        (ie_q),
      .rsp         (rsp),
      .rom_addr    (rom_addr),
      .ram_we_wram (ram_we_wram),
      .ram_we_oam  (ram_we_oam),
      .wram_addr   (wram_addr),
      .oam_addr    (oam_addr),
      .wdata       (wdata),
      .if_we       (if_we),
      .ie_we       (ie_we),
      .dma_start   (dma_start),
      .dma_page    (dma_page)
   );

   internal_ram u_ram (
      .clock       (clock),
      .ram_we_wram (ram_we_wram),
      .ram_we_oam  (ram_we_oam),
      .wram_addr   (wram_addr),
      .oam_addr    (oam_addr),
      .wdata       (wdata),
      .wram_rdata  (wram_rdata),
      .oam_rdata   (oam_rdata)
   );

   interrupt_flags u_irq (
      .clock   (clock),
      .reset   (reset),
      .if_we   (if_we),
      .ie_we   (ie_we),
      .wdata   (wdata),
      .irq_req (irq_req),
      .if_q    (if_q),
      .ie_q    (ie_q),
      .irq     (irq)
   );

endmodule

`default_nettype wire

/* verilog/internal_ram.sv */
//####################################################################
// On-chip storage: 8 KiB of work RAM and the 160-byte OAM. Both
// arrays read synchronously, data one cycle after the address.
//####################################################################

`timescale 1ns/10ps
`default_nettype none
`include "gb_bus_defs.svh"

module internal_ram (
   input  logic                          clock,
   input  logic                          ram_we_wram,
   input  logic                          ram_we_oam,
   input  logic [`GB_WRAM_ADDR_BITS-1:0] wram_addr,
   input  logic [7:0]                    oam_addr,
   input  logic [7:0]                    wdata,
   output logic [7:0]                    wram_rdata,
   output logic [7:0]                    oam_rdata
);

   logic [7:0] wram_mem [0:(1 << `GB_WRAM_ADDR_BITS)-1];
   logic [7:0] oam_mem  [0:`GB_OAM_BYTES-1];

   // Work RAM, read before write on the same address
   always_ff @(posedge clock) begin
      if (ram_we_wram) begin
         wram_mem[wram_addr] <= wdata;
      end
      wram_rdata <= wram_mem[wram_addr];
   end

   // OAM
   always_ff @(posedge clock) begin
      if (ram_we_oam) begin
         oam_mem[oam_addr] <= wdata;
      end
      oam_rdata <= oam_mem[oam_addr];
   end

endmodule

`default_nettype wire

/* verilog/interrupt_flags.sv */
//####################################################################
// Interrupt flag (IF) and enable (IE) registers. Request pulses set
// flags, the CPU clears them by writing IF; irq is a plain level.
//####################################################################

`timescale 1ns/10ps
`default_nettype none

module interrupt_flags import gb_bus_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  logic       if_we,
   input  logic       ie_we,
   input  logic [7:0] wdata,
   input  irq_bits_t  irq_req,
   output irq_bits_t  if_q,
   output irq_bits_t  ie_q,
   output logic       irq
);

   irq_bits_t if_next;

   // New requests win over a clearing write in the same cycle
   always_comb begin
      if (if_we)
         if_next = irq_bits_t'(wdata[4:0]);
      else
         if_next = if_q;
      if_next = if_next | irq_req;
      // No serial port
      if_next.serial = 1'b0;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         if_q <= if_next;
         if (ie_we) begin
            ie_q <= irq_bits_t'(wdata[4:0]);
         end
      end
   end

   assign irq = |(if_q & ie_q);

endmodule

`default_nettype wire

/* verilog/memory_map.sv */
//####################################################################
// Address decoder for the granted access. Drives target strobes,
// keeps the boot overlay and DMA page registers, forms the flash
// address and returns read data one cycle after acceptance.
//####################################################################

`timescale 1ns/10ps
`default_nettype none
`include "gb_bus_defs.svh"

module memory_map import gb_bus_pkg::*; (
   input  logic                          clock,
   input  logic                          reset,
   input  bus_req_t                      grant_req,
   input  bus_owner_e                    grant_owner,
   input  logic [7:0]                    rom_data,
   input  logic [7:0]                    wram_rdata,
   input  logic [7:0]                    oam_rdata,
   input  irq_bits_t                     if_q,
   input  irq_bits_t                     ie_q,
   output bus_rsp_t                      rsp,
   output logic [`GB_ROM_ADDR_WIDTH-1:0] rom_addr,
   output logic                          ram_we_wram,
   output logic                          ram_we_oam,
   output logic [`GB_WRAM_ADDR_BITS-1:0] wram_addr,
   output logic [7:0]                    oam_addr,
   output logic [7:0]                    wdata,
   output logic                          if_we,
   output logic                          ie_we,
   output logic                          dma_start,
   output logic [7:0]                    dma_page
);

   logic [15:0] addr;
   logic [15:0] wram_offset;
   bus_target_e target;
   logic        rd_acc;
   logic        wr_acc;
   logic [7:0]  boot_q;
   logic        rsp_valid_q;
   bus_owner_e  rsp_owner_q;
   bus_target_e rd_target_q;
   logic [7:0]  rd_data_q;

   assign addr   = grant_req.addr;
   assign rd_acc = grant_req.valid && !grant_req.we;
   assign wr_acc = grant_req.valid && grant_req.we;

   always_comb begin
      if (addr <= `GB_CART_END)
         target = TGT_ROM;
      else if (addr >= `GB_WRAM_START && addr <= `GB_ECHO_END)
         target = TGT_WRAM;
      else if (addr >= `GB_OAM_START && addr <= `GB_OAM_END)
         target = TGT_OAM;
      else if (addr == `GB_MMIO_IF)
         target = TGT_IF;
      else if (addr == `GB_MMIO_IE)
         target = TGT_IE;
      else if (addr == `GB_MMIO_BOOT)
         target = TGT_BOOT;
      else if (addr == `GB_MMIO_DMA)
         target = TGT_DMA;
      else
         target = TGT_NONE;
   end

   // Echo region folds onto work RAM
   always_comb begin
      if (addr > `GB_WRAM_END)
         wram_offset = addr - `GB_ECHO_START;
      else
         wram_offset = addr - `GB_WRAM_START;
   end

   assign wram_addr   = wram_offset[`GB_WRAM_ADDR_BITS-1:0];
   assign oam_addr    = addr[7:0];
   assign wdata       = grant_req.wdata;
   assign ram_we_wram = wr_acc && (target == TGT_WRAM);
   assign ram_we_oam  = wr_acc && (target == TGT_OAM);
   assign if_we       = wr_acc && (target == TGT_IF);
   assign ie_we       = wr_acc && (target == TGT_IE);

   // Boot image sits in front of the cartridge until bit 0 is set
   always_comb begin
      if (!boot_q[0] && addr <= `GB_BOOT_WINDOW_END)
         rom_addr = {8'h00, addr};
      else
         rom_addr = {8'h00, addr} + {8'h00, `GB_CART_OFFSET};
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rsp_valid_q <= 1'b0;
         boot_q      <= 8'h00;
         dma_start   <= 1'b0;
         dma_page    <= 8'h00;
      end else begin
         rsp_valid_q <= rd_acc;
         // DMA sees the start one cycle after the register write
         dma_start   <= wr_acc && (target == TGT_DMA);
         if (wr_acc && target == TGT_BOOT)
            boot_q <= grant_req.wdata;
         if (wr_acc && target == TGT_DMA)
            dma_page <= grant_req.wdata;
      end
   end

   // Sample the register and flash sources at the accepting edge
   always_ff @(posedge clock) begin
      if (rd_acc) begin
         rsp_owner_q <= grant_owner;
         rd_target_q <= target;
         case (target)
            TGT_ROM:  rd_data_q <= rom_data;
            TGT_IF:   rd_data_q <= {3'b000, if_q};
            TGT_IE:   rd_data_q <= {3'b000, ie_q};
            TGT_BOOT: rd_data_q <= boot_q;
            TGT_DMA:  rd_data_q <= dma_page;
            default:  rd_data_q <= 8'h00;
         endcase
      end
   end

   // RAM outputs are already registered, so only the select is late
   always_comb begin
      rsp.valid = rsp_valid_q;
      rsp.owner = rsp_owner_q;
      case (rd_target_q)
         TGT_WRAM: rsp.data = wram_rdata;
         TGT_OAM:  rsp.data = oam_rdata;
         default:  rsp.data = rd_data_q;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/oam_dma.sv */
//####################################################################
// OAM DMA engine. Started by a write to the DMA register, it copies
// one page of 160 bytes into OAM, one read and one write per byte.
//####################################################################

`timescale 1ns/10ps
`default_nettype none
`include "gb_bus_defs.svh"

module oam_dma import gb_bus_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  logic       dma_start,
   input  logic [7:0] dma_page,
   input  bus_rsp_t   dma_rsp,
   output bus_req_t   dma_req,
   output logic       dma_busy
);

   dma_state_e state;
   logic [7:0] byte_cnt;
   logic       last_byte;

   assign last_byte = (byte_cnt == 8'(`GB_OAM_BYTES - 1));
   assign dma_busy  = (state != DMA_IDLE);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state    <= DMA_IDLE;
         byte_cnt <= 8'd0;
      end else begin
         case (state)
            DMA_IDLE: begin
               if (dma_start) begin
                  state    <= DMA_READ;
                  byte_cnt <= 8'd0;
               end
            end
            DMA_READ: begin
               state <= DMA_WRITE;
            end
            DMA_WRITE: begin
               if (last_byte) begin
                  state <= DMA_IDLE;
               end else begin
                  state    <= DMA_READ;
                  byte_cnt <= byte_cnt + 8'd1;
               end
            end
            default: begin
               state <= DMA_IDLE;
            end
         endcase
      end
   end

   // Write cycle forwards the byte returned for the read just before
   always_comb begin
      dma_req       = '0;
      dma_req.valid = (state == DMA_READ) || (state == DMA_WRITE);
      if (state == DMA_WRITE) begin
         dma_req.we    = 1'b1;
         dma_req.addr  = `GB_OAM_START + 16'(byte_cnt);
         dma_req.wdata = dma_rsp.data;
      end else begin
         dma_req.addr = {dma_page, byte_cnt};
      end
   end

   // Read data must be back through the bus in time for the write
   a_rsp_for_write: assert property (
      @(posedge clock) disable iff (reset)
      (state == DMA_WRITE) |-> dma_rsp.valid
   );

   a_write_in_oam: assert property (
      @(posedge clock) disable iff (reset)
      (dma_req.valid && dma_req.we) |->
         (dma_req.addr >= `GB_OAM_START && dma_req.addr <= `GB_OAM_END)
   );

endmodule

`default_nettype wire
